// ==== common/video_pkg.sv ====
// Shared video types and geometry; assumes a 480x320 source shown on a 640x480 raster
package video_pkg;

	// Pixel layout is red in 7..0, green in 15..8 and blue in 23..16
	localparam int pixel_w = 24;
	localparam int color_w = 8;
	typedef logic [pixel_w-1:0] pixel_t;

	// A video address holds the row in 19..9 and the column in 8..0
	localparam int vid_addr_w = 20;
	localparam int col_w = 9;
	localparam int row_w = vid_addr_w - col_w;
	typedef logic [vid_addr_w-1:0] vid_addr_t;

	// The RAM only keeps the low address bits, which is four source rows
	localparam int ram_addr_w = 11;
	localparam int ram_depth = 1 << ram_addr_w;

	// Source image as the renderer draws it and the LCD shows it
	localparam int lcd_width = 480;
	localparam int lcd_height = 320;

	// HDMI raster, 640x480 at the usual 800x525 totals
	localparam int hdmi_h_active = 640;
	localparam int hdmi_h_total = 800;
	localparam int hdmi_v_active = 480;
	localparam int hdmi_v_total = 525;

	// Sync pulses are given as start and end counter values, end excluded
	localparam int hsync_start = 656;
	localparam int hsync_end = 752;
	localparam int vsync_start = 490;
	localparam int vsync_end = 492;

	// Raster counter widths, wide enough for the totals above
	localparam int hcnt_w = $clog2(hdmi_h_total);
	localparam int vcnt_w = $clog2(hdmi_v_total);

	// Number of line strobes after a field strobe that leave the row at 0
	localparam int overscan_lines = 38;
	localparam int overscan_w = $clog2(overscan_lines + 1);

	// Upscale phases
	// Every fourth column and every third line repeat the previous source word
	localparam int phase_w = 2;
	localparam int col_rep_phase = 3;
	localparam int line_rep_phase = 2;

endpackage

// ==== rtl/video_ram.sv ====
// Two-clock block RAM with read-before-write on port A and a read-only port B; no reset
`timescale 1ns/1ps

module video_ram (
	input  logic                             clk_a,
	input  logic                             we_a,
	input  logic [video_pkg::ram_addr_w-1:0] addr_a,
	input  video_pkg::pixel_t                din_a,
	output video_pkg::pixel_t                dout_a,
	input  logic                             clk_b,
	input  logic [video_pkg::ram_addr_w-1:0] addr_b,
	output video_pkg::pixel_t                dout_b
);
	import video_pkg::*;

	// Storage for four source rows of 512 words each
	pixel_t mem [0:ram_depth-1];

	// Port A writes on a strobe and always reads the word at the same address
	// The read returns the old contents when the same address is written
	always_ff @(posedge clk_a) begin
		if (we_a) begin
			mem[addr_a] <= din_a;
		end
		dout_a <= mem[addr_a];
	end

	// Port B runs on its own clock and only reads
	// Its data shows up one clk_b edge after the address
	always_ff @(posedge clk_b) begin
		dout_b <= mem[addr_b];
	end

endmodule

// ==== rtl/hdmi_timing.sv ====
// 640x480 raster with positive sync pulses; reset must cover at least one pixel_clk edge
`timescale 1ns/1ps

module hdmi_timing (
	input  logic pixel_clk,
	input  logic reset,
	output logic fetch_next,
	output logic next_line,
	output logic next_field,
	output logic de,
	output logic hsync,
	output logic vsync
);
	import video_pkg::*;

	logic [hcnt_w-1:0] h_cnt;
	logic [vcnt_w-1:0] v_cnt;
	logic              line_end;
	logic              field_end;
	logic              active;

	// Decodes of the current raster position
	assign line_end = (h_cnt == hcnt_w'(hdmi_h_total - 1));
	assign field_end = line_end && (v_cnt == vcnt_w'(hdmi_v_total - 1));
	assign active = (h_cnt < hcnt_w'(hdmi_h_active)) && (v_cnt < vcnt_w'(hdmi_v_active));

	// Strobes to the scaler are single pixel_clk pulses taken straight from the counters
	// The scaler address is therefore set up while the counters sit on the pixel
	assign fetch_next = active;
	assign next_line = line_end;
	assign next_field = field_end;

	// Pixel and line counters
	always_ff @(posedge pixel_clk) begin
		if (reset) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (line_end) begin
			h_cnt <= '0;
			if (field_end) begin
				v_cnt <= '0;
			end else begin
				v_cnt <= v_cnt + 1'b1;
			end
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	// The RAM read is registered, so the panel controls are held back one pixel_clk
	// That lines de, hsync and vsync up with the colour that the RAM returns
	always_ff @(posedge pixel_clk) begin
		if (reset) begin
			de <= 1'b0;
			hsync <= 1'b0;
			vsync <= 1'b0;
		end else begin
			de <= active;
			hsync <= (h_cnt >= hcnt_w'(hsync_start)) && (h_cnt < hcnt_w'(hsync_end));
			vsync <= (v_cnt >= vcnt_w'(vsync_start)) && (v_cnt < vcnt_w'(vsync_end));
		end
	end

endmodule

// ==== video_mem/hdmi_scaler.sv ====
// Upscales 480x320 to 640x480 by plain repetition; reset is sampled on pixel_clk only
`timescale 1ns/1ps

module hdmi_scaler (
	input  logic                 pixel_clk,
	input  logic                 reset,
	input  logic                 fetch_next,
	input  logic                 next_line,
	input  logic                 next_field,
	output video_pkg::vid_addr_t scan_addr
);
	import video_pkg::*;

	logic [row_w-1:0]      row_q;
	logic [col_w-1:0]      col_q;
	logic [phase_w-1:0]    col_phase;
	logic [phase_w-1:0]    line_phase;
	logic [overscan_w-1:0] skip_cnt;
	logic                  in_overscan;
	logic                  row_last;

	// The first lines of each field fall in the overscan band and stay on row 0
	assign in_overscan = (skip_cnt < overscan_w'(overscan_lines));

	// Rows never move past the last source row, even through vertical blanking
	assign row_last = (row_q >= row_w'(lcd_height - 1));

	// Row and column pack straight into the video address layout
	assign scan_addr = {row_q, col_q};

	always_ff @(posedge pixel_clk) begin
		if (reset) begin
			row_q <= '0;
			col_q <= '0;
			col_phase <= '0;
			line_phase <= '0;
			skip_cnt <= '0;
		end else if (next_field) begin
			// Field strobe starts the scan over at the top left corner
			row_q <= '0;
			col_q <= '0;
			col_phase <= '0;
			line_phase <= '0;
			skip_cnt <= '0;
		end else if (next_line) begin
			col_q <= '0;
			col_phase <= '0;
			if (in_overscan) begin
				skip_cnt <= skip_cnt + 1'b1;
			end else begin
				// Three output lines cover two source rows, the third one repeats
				if (line_phase == phase_w'(line_rep_phase)) begin
					line_phase <= '0;
				end else begin
					line_phase <= line_phase + 1'b1;
					if (!row_last) begin
						row_q <= row_q + 1'b1;
					end
				end
			end
		end else if (fetch_next) begin
			// Four output pixels cover three source columns
			// On the last phase the column is held so the next pixel repeats it
			col_phase <= col_phase + 1'b1;
			if (col_phase != phase_w'(col_rep_phase)) begin
				col_q <= col_q + 1'b1;
			end
		end
	end

endmodule

// ==== video_mem/lcd_reader.sv ====
// Native 480x320 LCD address walker; stalls at the end of the row that HDMI is reading
`timescale 1ns/1ps

module lcd_reader (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        lcd_next_pixel,
	input  logic [video_pkg::row_w-1:0] hdmi_row,
	output video_pkg::vid_addr_t        lcd_addr,
	output logic                        lcd_wait,
	output logic                        lcd_newfield
);
	import video_pkg::*;

	logic [row_w-1:0] row_q;
	logic [row_w-1:0] row_d;
	logic [col_w-1:0] col_q;
	logic [col_w-1:0] col_d;
	logic             step;
	logic             row_end;
	logic             field_end;

	// A pixel strobe only counts while the walker is not held
	assign step = lcd_next_pixel && !lcd_wait;

	assign row_end = (col_q == col_w'(lcd_width - 1));
	assign field_end = row_end && (row_q == row_w'(lcd_height - 1));

	assign lcd_addr = {row_q, col_q};

	// Next address
	// The last pixel of the image wraps to 0, the last column wraps to the next row
	always_comb begin
		row_d = row_q;
		col_d = col_q;
		if (step) begin
			if (field_end) begin
				row_d = '0;
				col_d = '0;
			end else if (row_end) begin
				row_d = row_q + 1'b1;
				col_d = '0;
			end else begin
				col_d = col_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			row_q <= '0;
			col_q <= '0;
			lcd_wait <= 1'b0;
			lcd_newfield <= 1'b0;
		end else begin
			row_q <= row_d;
			col_q <= col_d;
			// The stall is decoded from the next address, so it is already up
			// on the cycle the walker lands on the last column of the HDMI row
			// It drops one cycle after the synchronized HDMI row moves on
			lcd_wait <= (col_d == col_w'(lcd_width - 1)) && (row_d == hdmi_row);
			// One cycle pulse when the image wraps back to address 0
			lcd_newfield <= step && field_end;
		end
	end

endmodule

// ==== video_mem/video_mem.sv ====
// Frame window with HDMI and LCD readers; scan address crosses clocks as a plain bus
`timescale 1ns/1ps

module video_mem (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 pixel_clk,
	input  video_pkg::vid_addr_t wr_addr,
	input  video_pkg::pixel_t    wr_data,
	input  logic                 wen,
	input  video_pkg::vid_addr_t rd_addr,
	input  logic                 fetch_next,
	input  logic                 next_line,
	input  logic                 next_field,
	input  logic                 lcd_next_pixel,
	output video_pkg::pixel_t    data_out,
	output video_pkg::vid_addr_t curr_vid_addr,
	output logic                 next_field_out,
	output logic                 lcd_wait,
	output logic                 lcd_newfield,
	output video_pkg::pixel_t    hdmi_pixel,
	output video_pkg::pixel_t    lcd_pixel
);
	import video_pkg::*;

	vid_addr_t             scan_addr;
	vid_addr_t             lcd_addr;
	logic [ram_addr_w-1:0] port_a_addr;
	vid_addr_t             addr_sync0;
	vid_addr_t             addr_sync1;
	logic                  field_pix;
	logic                  field_sync0;
	logic                  field_sync1;

	// Renderer port shares one address between write and readback, write wins
	assign port_a_addr = wen ? wr_addr[ram_addr_w-1:0] : rd_addr[ram_addr_w-1:0];

	// Both copies take every write, so the pair acts as one RAM with three ports
	// This copy feeds the HDMI scan on pixel_clk and the renderer readback
	video_ram ram_hdmi (
		.clk_a  (clk),
		.we_a   (wen),
		.addr_a (port_a_addr),
		.din_a  (wr_data),
		.dout_a (data_out),
		.clk_b  (pixel_clk),
		.addr_b (scan_addr[ram_addr_w-1:0]),
		.dout_b (hdmi_pixel)
	);

	// This copy feeds the LCD on the system clock and its port A read goes nowhere
	video_ram ram_lcd (
		.clk_a  (clk),
		.we_a   (wen),
		.addr_a (port_a_addr),
		.din_a  (wr_data),
		.dout_a (),
		.clk_b  (clk),
		.addr_b (lcd_addr[ram_addr_w-1:0]),
		.dout_b (lcd_pixel)
	);

	hdmi_scaler u_hdmi_scaler (
		.pixel_clk  (pixel_clk),
		.reset      (reset),
		.fetch_next (fetch_next),
		.next_line  (next_line),
		.next_field (next_field),
		.scan_addr  (scan_addr)
	);

	// LCD stalls against the synchronized HDMI row
	lcd_reader u_lcd_reader (
		.clk            (clk),
		.reset          (reset),
		.lcd_next_pixel (lcd_next_pixel),
		.hdmi_row       (curr_vid_addr[vid_addr_w-1:col_w]),
		.lcd_addr       (lcd_addr),
		.lcd_wait       (lcd_wait),
		.lcd_newfield   (lcd_newfield)
	);

	// Field strobe is decoded from counters, so it gets a flop before it crosses
	always_ff @(posedge pixel_clk) begin
		if (reset) begin
			field_pix <= 1'b0;
		end else begin
			field_pix <= next_field;
		end
	end

	// Two synchronizer flops and an output register on the system clock
	// The address bits may land on different edges while the scan moves
	always_ff @(posedge clk) begin
		if (reset) begin
			addr_sync0 <= '0;
			addr_sync1 <= '0;
			curr_vid_addr <= '0;
			field_sync0 <= 1'b0;
			field_sync1 <= 1'b0;
			next_field_out <= 1'b0;
		end else begin
			addr_sync0 <= scan_addr;
			addr_sync1 <= addr_sync0;
			curr_vid_addr <= addr_sync1;
			field_sync0 <= field_pix;
			field_sync1 <= field_sync0;
			next_field_out <= field_sync1;
		end
	end

endmodule

// ==== rtl/video_out_top.sv ====
// Video back end top; renderer must stay a row ahead of curr_vid_addr, no TMDS encoding
`timescale 1ns/1ps

module video_out_top (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 pixel_clk,
	input  video_pkg::vid_addr_t wr_addr,
	input  video_pkg::pixel_t    wr_data,
	input  logic                 wen,
	input  video_pkg::vid_addr_t rd_addr,
	input  logic                 lcd_next_pixel,
	output video_pkg::pixel_t    data_out,
	output video_pkg::vid_addr_t curr_vid_addr,
	output logic                 next_field_out,
	output logic                 lcd_wait,
	output logic                 lcd_newfield,
	output logic [7:0]           lcd_red,
	output logic [7:0]           lcd_green,
	output logic [7:0]           lcd_blue,
	output logic [7:0]           red,
	output logic [7:0]           green,
	output logic [7:0]           blue,
	output logic                 de,
	output logic                 hsync,
	output logic                 vsync
);
	import video_pkg::*;

	logic   fetch_next;
	logic   next_line;
	logic   next_field;
	pixel_t hdmi_pixel;
	pixel_t lcd_pixel;

	// Raster timing for the HDMI side
	hdmi_timing u_hdmi_timing (
		.pixel_clk  (pixel_clk),
		.reset      (reset),
		.fetch_next (fetch_next),
		.next_line  (next_line),
		.next_field (next_field),
		.de         (de),
		.hsync      (hsync),
		.vsync      (vsync)
	);

	video_mem u_video_mem (
		.clk            (clk),
		.reset          (reset),
		.pixel_clk      (pixel_clk),
		.wr_addr        (wr_addr),
		.wr_data        (wr_data),
		.wen            (wen),
		.rd_addr        (rd_addr),
		.fetch_next     (fetch_next),
		.next_line      (next_line),
		.next_field     (next_field),
		.lcd_next_pixel (lcd_next_pixel),
		.data_out       (data_out),
		.curr_vid_addr  (curr_vid_addr),
		.next_field_out (next_field_out),
		.lcd_wait       (lcd_wait),
		.lcd_newfield   (lcd_newfield),
		.hdmi_pixel     (hdmi_pixel),
		.lcd_pixel      (lcd_pixel)
	);

	// Red sits in the low byte and blue in the high byte
	assign red = hdmi_pixel[color_w-1:0];
	assign green = hdmi_pixel[2*color_w-1:color_w];
	assign blue = hdmi_pixel[3*color_w-1:2*color_w];
	assign lcd_red = lcd_pixel[color_w-1:0];
	assign lcd_green = lcd_pixel[2*color_w-1:color_w];
	assign lcd_blue = lcd_pixel[3*color_w-1:2*color_w];

endmodule

// ==== bench/video_out_assertions.sv ====
// Bound into video_mem; checks the LCD field pulse and stall with reset sampled on clk
`timescale 1ns/1ps

module video_out_assertions (
	input logic                 clk,
	input logic                 reset,
	input logic                 lcd_wait,
	input logic                 lcd_newfield,
	input video_pkg::vid_addr_t lcd_addr
);

	// The field pulse of the LCD walker is a single clk wide
	newfield_one_cycle: assert property (@(posedge clk) disable iff (reset)
		lcd_newfield |=> !lcd_newfield)
		else $error("lcd_newfield stayed high for more than one cycle");

	// While the walker is held, no strobe may move the LCD address
	addr_held_in_wait: assert property (@(posedge clk) disable iff (reset)
		lcd_wait |=> $stable(lcd_addr))
		else $error("LCD address moved while lcd_wait was high");

	// Reset is synchronous, so the stall is low one edge after reset is seen
	wait_low_at_reset: assert property (@(posedge clk)
		reset |=> !lcd_wait)
		else $error("lcd_wait was high after a reset edge");

endmodule

bind video_mem video_out_assertions u_video_out_assertions (
	.clk          (clk),
	.reset        (reset),
	.lcd_wait     (lcd_wait),
	.lcd_newfield (lcd_newfield),
	.lcd_addr     (lcd_addr)
);

// ==== bench/tb_video_out.sv ====
// Directed testbench; the renderer model stays two rows ahead of the synchronized HDMI row
`timescale 1ns/1ps

module tb_video_out;
	import video_pkg::*;

	localparam int wait_limit = 600000;
	localparam int step_limit = 1000000;

	logic       clk;
	logic       reset;
	logic       pixel_clk;
	vid_addr_t  wr_addr;
	pixel_t     wr_data;
	logic       wen;
	vid_addr_t  rd_addr;
	logic       lcd_next_pixel;
	pixel_t     data_out;
	vid_addr_t  curr_vid_addr;
	logic       next_field_out;
	logic       lcd_wait;
	logic       lcd_newfield;
	logic [7:0] lcd_red;
	logic [7:0] lcd_green;
	logic [7:0] lcd_blue;
	logic [7:0] red;
	logic [7:0] green;
	logic [7:0] blue;
	logic       de;
	logic       hsync;
	logic       vsync;

	// Random colour seeds, one per row modulo 16
	pixel_t tbl [0:15];
	int     errors;
	int     checks;
	int     tests;
	logic   render_on;
	int     wr_row;
	int     wr_col;
	int     exp_row;
	int     exp_col;
	int     newfield_cnt;

	video_out_top u_video_out_top (
		.clk            (clk),
		.reset          (reset),
		.pixel_clk      (pixel_clk),
		.wr_addr        (wr_addr),
		.wr_data        (wr_data),
		.wen            (wen),
		.rd_addr        (rd_addr),
		.lcd_next_pixel (lcd_next_pixel),
		.data_out       (data_out),
		.curr_vid_addr  (curr_vid_addr),
		.next_field_out (next_field_out),
		.lcd_wait       (lcd_wait),
		.lcd_newfield   (lcd_newfield),
		.lcd_red        (lcd_red),
		.lcd_green      (lcd_green),
		.lcd_blue       (lcd_blue),
		.red            (red),
		.green          (green),
		.blue           (blue),
		.de             (de),
		.hsync          (hsync),
		.vsync          (vsync)
	);

	// System clock at 8 ns and pixel clock at 10 ns
	always #4 clk = ~clk;
	always #5 pixel_clk = ~pixel_clk;

	always @(posedge clk) begin
		if (lcd_newfield) begin
			newfield_cnt++;
		end
	end

	// Source pixel of row r and column c as the renderer draws it
	function automatic pixel_t pix(int r, int c);
		return tbl[r % 16] ^ (pixel_t'(r) << 12) ^ pixel_t'(c);
	endfunction

	// How many rows the renderer row is ahead of the HDMI row, modulo the image height
	function automatic int rows_ahead(int r);
		return (r - int'(curr_vid_addr[vid_addr_w-1:col_w]) + lcd_height) % lcd_height;
	endfunction

	// Renderer model writes one pixel per clk into slot row mod 4 while it is not too far ahead
	// Each row also gets column 480, which the HDMI scan reads on the last pixel of a line
	always @(posedge clk) begin
		#1;
		if (render_on) begin
			if (rows_ahead(wr_row) <= 2) begin
				wen = 1'b1;
				wr_addr = {row_w'(wr_row), col_w'(wr_col)};
				wr_data = pix(wr_row, wr_col);
				if (wr_col == lcd_width) begin
					wr_col = 0;
					wr_row = (wr_row == lcd_height - 1) ? 0 : wr_row + 1;
				end else begin
					wr_col++;
				end
			end else begin
				wen = 1'b0;
			end
		end
	end

	task automatic check(string name, logic [31:0] got, logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic timed_out(string what);
		errors++;
		$display("timed out while waiting for %s", what);
	endtask

	task automatic test_done(string name, int e0);
		tests++;
		$display("test %s finished with %0d errors", name, errors - e0);
	endtask

	task automatic reset_test();
		int e0;
		e0 = errors;
		reset = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		// No pixel_clk edge has seen reset low yet, so the raster outputs are still cleared
		check("lcd_wait", lcd_wait, 0);
		check("lcd_newfield", lcd_newfield, 0);
		check("next_field_out", next_field_out, 0);
		check("de", de, 0);
		check("hsync", hsync, 0);
		check("vsync", vsync, 0);
		check("curr_vid_addr", curr_vid_addr, 0);
		test_done("reset", e0);
	endtask

	task automatic port_a_test();
		int        e0;
		vid_addr_t addrs [$];
		pixel_t    shadow [0:ram_depth-1];
		vid_addr_t a;
		pixel_t    d;
		e0 = errors;
		for (int i = 0; i < 24; i++) begin
			// The last writes hit earlier slots through other upper address bits
			if (i >= 16) begin
				a = addrs[i-16] ^ vid_addr_t'(($urandom % 512) << ram_addr_w);
			end else begin
				a = vid_addr_t'($urandom);
			end
			d = pixel_t'($urandom);
			wr_addr = a;
			wr_data = d;
			wen = 1'b1;
			shadow[a[ram_addr_w-1:0]] = d;
			addrs.push_back(a);
			@(posedge clk);
			#1;
		end
		wen = 1'b0;
		foreach (addrs[i]) begin
			rd_addr = addrs[i] ^ vid_addr_t'(i << ram_addr_w);
			@(posedge clk);
			#1;
			check("data_out", data_out, shadow[addrs[i][ram_addr_w-1:0]]);
		end
		test_done("port_a_readback", e0);
	endtask

	// Lets the renderer fill rows 0 to 2 while HDMI sits in the overscan band
	task automatic render_start();
		int n;
		render_on = 1'b1;
		n = 0;
		while (wr_row < 3 && n < 4000) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (wr_row < 3) begin
			timed_out("renderer prefill");
		end
	endtask

	// One LCD strobe, then a look at the colour of the new address
	task automatic lcd_step();
		logic held;
		held = lcd_wait;
		lcd_next_pixel = 1'b1;
		@(posedge clk);
		#1;
		lcd_next_pixel = 1'b0;
		if (!held) begin
			if (exp_col == lcd_width - 1) begin
				exp_col = 0;
				exp_row = (exp_row == lcd_height - 1) ? 0 : exp_row + 1;
			end else begin
				exp_col++;
			end
		end
		@(posedge clk);
		#1;
		check("lcd_pixel", {lcd_blue, lcd_green, lcd_red}, pix(exp_row, exp_col));
	endtask

	task automatic lcd_stall_test();
		int e0;
		int n;
		e0 = errors;
		for (int i = 0; i < lcd_width - 1; i++) begin
			lcd_step();
		end
		// HDMI is still on row 0, so the walker is held on the last column
		check("lcd_wait", lcd_wait, 1);
		repeat (4) begin
			lcd_step();
			check("lcd_wait", lcd_wait, 1);
		end
		n = 0;
		while (lcd_wait && n < wait_limit) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (lcd_wait) begin
			timed_out("lcd_wait to drop");
		end
		// The colour check inside the step shows the walk resumed at row 1, column 0
		lcd_step();
		check("lcd_wait", lcd_wait, 0);
		test_done("lcd_walk_stall", e0);
	endtask

	task automatic hdmi_scaling_test();
		int   e0;
		int   n;
		int   line;
		int   c;
		int   j;
		int   h;
		logic de_prev;
		e0 = errors;
		n = 0;
		while (!vsync && n < hdmi_h_total * hdmi_v_total) begin
			@(negedge pixel_clk);
			n++;
		end
		n = 0;
		while (vsync && n < 4 * hdmi_h_total) begin
			@(negedge pixel_clk);
			n++;
		end
		if (vsync || n == 0) begin
			timed_out("vsync");
		end else begin
			check("vsync width", n, (vsync_end - vsync_start) * hdmi_h_total);
		end
		// Lines are counted on each falling de, columns on each de cycle
		// The pixel position within a line starts over on each rising de
		line = 0;
		c = 0;
		h = -1;
		de_prev = 1'b0;
		n = 0;
		while (line < hdmi_v_active && n < hdmi_h_total * hdmi_v_total) begin
			@(negedge pixel_clk);
			n++;
			if (de && !de_prev) begin
				h = 0;
			end else if (h >= 0) begin
				h++;
			end
			if (h >= 0) begin
				check("hsync", hsync, (h >= hsync_start) && (h < hsync_end));
			end
			if (de) begin
				j = line - overscan_lines;
				if (j < 0) begin
					check("hdmi_pixel", {blue, green, red}, pix(0, c - c / 4));
				end else begin
					check("hdmi_pixel", {blue, green, red}, pix(j - j / 3, c - c / 4));
				end
				c++;
			end else if (de_prev) begin
				check("hdmi columns per line", c, hdmi_h_active);
				line++;
				c = 0;
			end
			de_prev = de;
		end
		if (line < hdmi_v_active) begin
			timed_out("HDMI active lines");
		end
		test_done("hdmi_scaling", e0);
	endtask

	task automatic lcd_field_test();
		int e0;
		int n;
		int moved;
		int r0;
		int c0;
		e0 = errors;
		// First the walker follows HDMI to the end of the current field
		n = 0;
		while (!(exp_row == 0 && exp_col == 0) && n < step_limit) begin
			lcd_step();
			n++;
		end
		if (n == step_limit) begin
			timed_out("LCD field wrap");
		end
		newfield_cnt = 0;
		moved = 0;
		n = 0;
		while (moved < lcd_width * lcd_height && n < step_limit) begin
			r0 = exp_row;
			c0 = exp_col;
			lcd_step();
			if (exp_row != r0 || exp_col != c0) begin
				moved++;
			end
			n++;
		end
		if (moved < lcd_width * lcd_height) begin
			timed_out("LCD full field walk");
		end
		check("lcd_newfield pulses", newfield_cnt, 1);
		check("lcd_pixel at address 0", {lcd_blue, lcd_green, lcd_red}, pix(0, 0));
		test_done("lcd_field", e0);
	endtask

	task automatic field_pulse_test();
		int e0;
		int n;
		e0 = errors;
		n = 0;
		while (!next_field_out && n < wait_limit) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (!next_field_out) begin
			timed_out("next_field_out");
		end else begin
			// Scan address and field strobe cross through chains of the same depth
			check("curr_vid_addr row", curr_vid_addr[vid_addr_w-1:col_w], 0);
		end
		n = 0;
		while (next_field_out && n < 8) begin
			@(posedge clk);
			#1;
			n++;
		end
		check("next_field_out", next_field_out, 0);
		test_done("field_pulse", e0);
	endtask

	initial begin
		void'($urandom(32'h985427cb));
		clk = 1'b0;
		pixel_clk = 1'b0;
		reset = 1'b1;
		wr_addr = '0;
		wr_data = '0;
		wen = 1'b0;
		rd_addr = '0;
		lcd_next_pixel = 1'b0;
		errors = 0;
		checks = 0;
		tests = 0;
		render_on = 1'b0;
		wr_row = 0;
		wr_col = 0;
		exp_row = 0;
		exp_col = 0;
		newfield_cnt = 0;
		for (int i = 0; i < 16; i++) begin
			tbl[i] = pixel_t'($urandom);
		end
		reset_test();
		port_a_test();
		render_start();
		lcd_stall_test();
		// The LCD keeps stepping behind the HDMI scan while one HDMI field is checked
		fork
			hdmi_scaling_test();
			lcd_field_test();
		join
		field_pulse_test();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
common/video_pkg.sv
rtl/video_ram.sv
rtl/hdmi_timing.sv
video_mem/hdmi_scaler.sv
video_mem/lcd_reader.sv
video_mem/video_mem.sv
rtl/video_out_top.sv
bench/video_out_assertions.sv
bench/tb_video_out.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module tb_video_out -Mdir obj_dir
	./obj_dir/Vtb_video_out | tee /dev/stderr | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
